// ==== verilog/cart_pkg.sv ====
package cart_pkg;

  // Console memory map selection
  typedef enum logic [1:0] {
    MAP_HIROM = 2'd0,
    MAP_LOROM = 2'd1
  } mapper_e;

  // Arbiter states, one bit each
  typedef enum logic [14:0] {
    ST_IDLE          = 15'h0001,
    ST_SNES_RD_ADDR  = 15'h0002,
    ST_SNES_RD_WAIT  = 15'h0004,
    ST_SNES_RD_END   = 15'h0008,
    ST_SNES_WR_ADDR  = 15'h0010,
    ST_SNES_WR_WAIT1 = 15'h0020,
    ST_SNES_WR_DATA  = 15'h0040,
    ST_SNES_WR_WAIT2 = 15'h0080,
    ST_SNES_WR_END   = 15'h0100,
    ST_MCU_RD_ADDR   = 15'h0200,
    ST_MCU_RD_WAIT   = 15'h0400,
    ST_MCU_RD_END    = 15'h0800,
    ST_MCU_WR_ADDR   = 15'h1000,
    ST_MCU_WR_WAIT   = 15'h2000,
    ST_MCU_WR_END    = 15'h4000
  } arb_state_e;

  // Save RAM sits at the top of the PSRAM
  localparam logic [23:0] SAVERAM_BASE = 24'hE00000;

endpackage

// ==== verilog/bus_sync.sv ====
`timescale 1ns/1ns

module bus_sync (
  input  logic clk2,
  input  logic reset,
  input  logic snes_cpu_clk,
  input  logic snes_write_n,
  output logic cycle_start,
  output logic cycle_end,
  output logic write_start
);

  // Newest sample in bit 0
  logic [5:0] cpu_clk_hist;
  logic [5:0] write_hist;

  always_ff @(posedge clk2) begin
    if (reset) begin
      // Fill with the present level, no edge seen out of reset
      cpu_clk_hist <= {6{snes_cpu_clk}};
      write_hist   <= {6{snes_write_n}};
    end else begin
      cpu_clk_hist <= {cpu_clk_hist[4:0], snes_cpu_clk};
      write_hist   <= {write_hist[4:0], snes_write_n};
    end
  end

  //////////////////////////////
  // Settled edge decode
  //////////////////////////////

  // Five stable samples before the new level filter out glitches
  assign cycle_start = (cpu_clk_hist == 6'b000001);
  assign cycle_end   = (cpu_clk_hist == 6'b111110);
  assign write_start = (write_hist == 6'b111110);

endmodule

// ==== verilog/cart_address_map.sv ====
`timescale 1ns/1ns

module cart_address_map
  import cart_pkg::*;
(
  input  logic [23:0] snes_addr,
  input  mapper_e     mapper,
  input  logic [23:0] rom_mask,
  input  logic [23:0] saveram_mask,
  output logic [23:0] rom_byte_addr,
  output logic        is_rom,
  output logic        is_saveram,
  output logic        is_writable,
  output logic        is_cart
);

  logic        hi_rom_hit;
  logic        hi_sram_hit;
  logic        lo_rom_hit;
  logic        lo_sram_hit;
  logic [23:0] hi_rom_addr;
  logic [23:0] hi_sram_off;
  logic [23:0] lo_rom_addr;
  logic [23:0] lo_sram_off;

  //////////////////////////////
  // HiROM
  //////////////////////////////

  assign hi_rom_hit  = snes_addr[22] | snes_addr[15];
  assign hi_sram_hit = (snes_addr[22:21] == 2'b01) && (snes_addr[15:13] == 3'b011);
  assign hi_rom_addr = {1'b0, snes_addr[22:0]};
  // 8 KB window per bank, banks 20..3f
  assign hi_sram_off = {6'b0, snes_addr[20:16], snes_addr[12:0]};

  //////////////////////////////
  // LoROM
  //////////////////////////////

  // Upper half of each bank only
  assign lo_rom_hit  = snes_addr[15];
  assign lo_sram_hit = (snes_addr[22:20] == 3'b111) && !snes_addr[15];
  assign lo_rom_addr = {2'b0, snes_addr[22:16], snes_addr[14:0]};
  assign lo_sram_off = {5'b0, snes_addr[19:16], snes_addr[14:0]};

  always_comb begin
    is_rom        = 1'b0;
    is_saveram    = 1'b0;
    rom_byte_addr = 24'h0;
    case (mapper)
      MAP_HIROM: begin
        if (hi_sram_hit) begin
          is_saveram    = 1'b1;
          rom_byte_addr = SAVERAM_BASE + (hi_sram_off & saveram_mask);
        end else if (hi_rom_hit) begin
          is_rom        = 1'b1;
          rom_byte_addr = hi_rom_addr & rom_mask;
        end
      end
      MAP_LOROM: begin
        if (lo_sram_hit) begin
          is_saveram    = 1'b1;
          rom_byte_addr = SAVERAM_BASE + (lo_sram_off & saveram_mask);
        end else if (lo_rom_hit) begin
          is_rom        = 1'b1;
          rom_byte_addr = lo_rom_addr & rom_mask;
        end
      end
      default: begin
        is_rom     = 1'b0;
        is_saveram = 1'b0;
      end
    endcase
  end

  // Only save RAM takes console writes
  assign is_writable = is_saveram;
  assign is_cart     = is_rom | is_saveram | is_writable;

endmodule

// ==== verilog/rom_arbiter.sv ====
`timescale 1ns/1ns

module rom_arbiter
  import cart_pkg::*;
#(
  parameter logic [3:0] RD_WAIT     = 4'd4,
  parameter logic [3:0] RD_WAIT_MCU = 4'd6,
  parameter logic [3:0] WR_WAIT1    = 4'd2,
  parameter logic [3:0] WR_WAIT2    = 4'd3,
  parameter logic [3:0] WR_WAIT_MCU = 4'd6
) (
  input  logic        clk2,
  input  logic        reset,
  input  logic        cycle_start,
  input  logic        write_start,
  input  logic        is_cart,
  input  logic        is_writable,
  input  logic [23:0] rom_byte_addr,
  input  logic [7:0]  snes_data_in,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  logic [23:0] mcu_addr,
  input  logic [7:0]  mcu_wdata,
  input  logic [15:0] rom_rdata,
  output logic [7:0]  snes_data_out,
  output logic [7:0]  mcu_rdata,
  output logic        mcu_rdy,
  output logic [22:0] rom_addr,
  output logic [15:0] rom_wdata,
  output logic        rom_we_n,
  output logic        rom_bhe_n,
  output logic        rom_ble_n
);

  arb_state_e  state;
  logic [3:0]  delay;
  logic        delay_done;
  logic        mcu_rd_pend;
  logic        mcu_wr_pend;
  logic        mcu_rdy_r;
  logic        mcu_end;
  logic [23:0] mcu_addr_q;
  logic [7:0]  mcu_wdata_q;
  logic [23:0] rom_addr_r;
  logic [7:0]  rom_wbyte;
  logic        rom_we_n_r;
  logic [7:0]  rom_lane;

  // Bit 0 set means odd byte, which is the low lane
  assign rom_lane   = rom_addr_r[0] ? rom_rdata[7:0] : rom_rdata[15:8];
  assign delay_done = (delay == 4'h0);
  assign mcu_end    = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  //////////////////////////////
  // MCU request tracking
  //////////////////////////////

  always_ff @(posedge clk2) begin
    if (reset) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy_r   <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy_r   <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy_r   <= 1'b0;
    end else if (mcu_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy_r   <= 1'b1;
    end
  end

  // Hold the request so a restarted access sees the same address
  always_ff @(posedge clk2) begin
    if (mcu_rrq | mcu_wrq) begin
      mcu_addr_q  <= mcu_addr;
      mcu_wdata_q <= mcu_wdata;
    end
  end

  //////////////////////////////
  // Arbiter FSM
  //////////////////////////////

  always_ff @(posedge clk2) begin
    if (reset) begin
      state      <= ST_IDLE;
      delay      <= 4'h0;
      rom_we_n_r <= 1'b1;
    end else if (cycle_start && is_cart) begin
      // Console always wins, any MCU access restarts later
      state      <= ST_SNES_RD_ADDR;
      rom_addr_r <= rom_byte_addr;
      rom_we_n_r <= 1'b1;
    end else if (write_start && is_cart) begin
      state      <= ST_SNES_WR_ADDR;
      rom_addr_r <= rom_byte_addr;
      rom_we_n_r <= !is_writable;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mcu_rd_pend) begin
            state <= ST_MCU_RD_ADDR;
          end else if (mcu_wr_pend) begin
            state <= ST_MCU_WR_ADDR;
          end
        end

        // Console read
        ST_SNES_RD_ADDR: begin
          delay <= RD_WAIT;
          state <= ST_SNES_RD_WAIT;
        end
        ST_SNES_RD_WAIT: begin
          delay         <= delay - 4'h1;
          snes_data_out <= rom_lane;
          if (delay_done) begin
            state <= ST_SNES_RD_END;
          end
        end
        ST_SNES_RD_END: begin
          snes_data_out <= rom_lane;
          state         <= ST_IDLE;
        end

        // Console write, data is valid only after the first wait
        ST_SNES_WR_ADDR: begin
          delay <= WR_WAIT1;
          state <= ST_SNES_WR_WAIT1;
        end
        ST_SNES_WR_WAIT1: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= ST_SNES_WR_DATA;
          end
        end
        ST_SNES_WR_DATA: begin
          rom_wbyte <= snes_data_in;
          delay     <= WR_WAIT2;
          state     <= ST_SNES_WR_WAIT2;
        end
        ST_SNES_WR_WAIT2: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= ST_SNES_WR_END;
          end
        end
        ST_SNES_WR_END: begin
          rom_we_n_r <= 1'b1;
          state      <= ST_IDLE;
        end

        // MCU read
        ST_MCU_RD_ADDR: begin
          rom_addr_r <= mcu_addr_q;
          delay      <= RD_WAIT_MCU;
          state      <= ST_MCU_RD_WAIT;
        end
        ST_MCU_RD_WAIT: begin
          delay     <= delay - 4'h1;
          mcu_rdata <= rom_lane;
          if (delay_done) begin
            state <= ST_MCU_RD_END;
          end
        end
        ST_MCU_RD_END: begin
          state <= ST_IDLE;
        end

        // MCU write
        ST_MCU_WR_ADDR: begin
          rom_addr_r <= mcu_addr_q;
          rom_wbyte  <= mcu_wdata_q;
          rom_we_n_r <= 1'b0;
          delay      <= WR_WAIT_MCU;
          state      <= ST_MCU_WR_WAIT;
        end
        ST_MCU_WR_WAIT: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            rom_we_n_r <= 1'b1;
            state      <= ST_MCU_WR_END;
          end
        end
        ST_MCU_WR_END: begin
          state <= ST_IDLE;
        end

        default: begin
          rom_we_n_r <= 1'b1;
          state      <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // PSRAM side
  //////////////////////////////

  assign rom_addr  = rom_addr_r[23:1];
  assign rom_wdata = {rom_wbyte, rom_wbyte};
  assign rom_we_n  = rom_we_n_r;

  // Mask the lane that is not addressed while writing
  assign rom_bhe_n = !rom_we_n_r ? rom_addr_r[0] : 1'b0;
  assign rom_ble_n = !rom_we_n_r ? !rom_addr_r[0] : 1'b0;

  assign mcu_rdy = mcu_rdy_r;

endmodule

// ==== verilog/snes_cart_top.sv ====
`timescale 1ns/1ns

module snes_cart_top
  import cart_pkg::*;
#(
  parameter logic [3:0] RD_WAIT     = 4'd4,
  parameter logic [3:0] RD_WAIT_MCU = 4'd6,
  parameter logic [3:0] WR_WAIT1    = 4'd2,
  parameter logic [3:0] WR_WAIT2    = 4'd3,
  parameter logic [3:0] WR_WAIT_MCU = 4'd6
) (
  input  logic        clk2,
  input  logic        reset,
  // Console bus
  input  logic [23:0] snes_addr,
  input  logic        snes_read_n,
  input  logic        snes_write_n,
  input  logic        snes_cpu_clk,
  input  logic [7:0]  snes_data_in,
  output logic [7:0]  snes_data_out,
  output logic        snes_data_oe,
  // MCU port
  input  logic [23:0] mcu_addr,
  input  logic [7:0]  mcu_wdata,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  output logic [7:0]  mcu_rdata,
  output logic        mcu_rdy,
  // Configuration
  input  mapper_e     mapper,
  input  logic [23:0] rom_mask,
  input  logic [23:0] saveram_mask,
  // PSRAM
  output logic [22:0] rom_addr,
  output logic [15:0] rom_wdata,
  output logic        rom_we_n,
  output logic        rom_bhe_n,
  output logic        rom_ble_n,
  input  logic [15:0] rom_rdata
);

  logic        cycle_start;
  logic        write_start;
  logic [23:0] rom_byte_addr;
  logic        is_writable;
  logic        is_cart;

  bus_sync u_bus_sync (
    .clk2         (clk2),
    .reset        (reset),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_write_n (snes_write_n),
    .cycle_start  (cycle_start),
    .cycle_end    (),
    .write_start  (write_start)
  );

  cart_address_map u_address_map (
    .snes_addr     (snes_addr),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .rom_byte_addr (rom_byte_addr),
    .is_rom        (),
    .is_saveram    (),
    .is_writable   (is_writable),
    .is_cart       (is_cart)
  );

  rom_arbiter #(
    .RD_WAIT     (RD_WAIT),
    .RD_WAIT_MCU (RD_WAIT_MCU),
    .WR_WAIT1    (WR_WAIT1),
    .WR_WAIT2    (WR_WAIT2),
    .WR_WAIT_MCU (WR_WAIT_MCU)
  ) u_arbiter (
    .clk2          (clk2),
    .reset         (reset),
    .cycle_start   (cycle_start),
    .write_start   (write_start),
    .is_cart       (is_cart),
    .is_writable   (is_writable),
    .rom_byte_addr (rom_byte_addr),
    .snes_data_in  (snes_data_in),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .rom_rdata     (rom_rdata),
    .snes_data_out (snes_data_out),
    .mcu_rdata     (mcu_rdata),
    .mcu_rdy       (mcu_rdy),
    .rom_addr      (rom_addr),
    .rom_wdata     (rom_wdata),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n)
  );

  // Drive the console bus only for cartridge reads
  assign snes_data_oe = !snes_read_n && is_cart;

endmodule

// ==== dv/tb_snes_cart_assert.sv ====
`timescale 1ns/1ns

module tb_snes_cart_assert
  import cart_pkg::*;
(
  input logic       clk2,
  input logic       reset,
  input arb_state_e state,
  input logic       mcu_rdy,
  input logic       rom_we_n,
  input logic       rom_bhe_n,
  input logic       rom_ble_n,
  input logic       is_writable
);

  logic mcu_end_state;
  logic mcu_busy_state;
  logic console_wr_state;

  assign mcu_end_state    = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign mcu_busy_state   = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_RD_WAIT) ||
                            (state == ST_MCU_RD_END) || (state == ST_MCU_WR_ADDR) ||
                            (state == ST_MCU_WR_WAIT) || (state == ST_MCU_WR_END);
  assign console_wr_state = (state == ST_SNES_WR_ADDR) || (state == ST_SNES_WR_WAIT1) ||
                            (state == ST_SNES_WR_DATA) || (state == ST_SNES_WR_WAIT2) ||
                            (state == ST_SNES_WR_END);

  // Ready only comes back through an MCU end state
  rdy_held_low: assert property (@(posedge clk2) disable iff (reset)
    (!mcu_rdy && !mcu_end_state) |=> !mcu_rdy)
    else $error("mcu_rdy rose without an MCU end state");

  no_rom_write: assert property (@(posedge clk2) disable iff (reset)
    !(console_wr_state && !is_writable && !rom_we_n))
    else $error("rom_we_n low in a console write to a read-only region");

  // A masked lane means a write is under way
  lane_mask_in_write: assert property (@(posedge clk2) disable iff (reset)
    (rom_bhe_n || rom_ble_n) |-> (console_wr_state || (state == ST_MCU_WR_WAIT)))
    else $error("byte lane masked outside a write state");

  mcu_state_not_ready: assert property (@(posedge clk2) disable iff (reset)
    mcu_busy_state |-> !mcu_rdy)
    else $error("mcu_rdy high while the arbiter serves the MCU");

endmodule

bind rom_arbiter tb_snes_cart_assert u_checks (
  .clk2        (clk2),
  .reset       (reset),
  .state       (state),
  .mcu_rdy     (mcu_rdy),
  .rom_we_n    (rom_we_n),
  .rom_bhe_n   (rom_bhe_n),
  .rom_ble_n   (rom_ble_n),
  .is_writable (is_writable)
);

// ==== dv/tb_snes_cart.sv ====
`timescale 1ns/1ns

module tb_snes_cart
  import cart_pkg::*;
;

  localparam int N_HI  = 40;
  localparam int N_LO  = 40;
  localparam int N_WR  = 12;
  localparam int N_MCU = 20;
  localparam int N_MIX = 16;
  // Console write test does four bus transactions per round
  localparam int N_TRANS   = N_HI + N_LO + 4 * N_WR + 2 * N_MCU + 2 * N_MIX + 10;
  localparam int WDOG_CLKS = N_TRANS * 60;

  logic        clk2;
  logic        reset;
  logic [23:0] snes_addr;
  logic        snes_read_n;
  logic        snes_write_n;
  logic        snes_cpu_clk;
  logic [7:0]  snes_data_in;
  logic [7:0]  snes_data_out;
  logic        snes_data_oe;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_wdata;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [7:0]  mcu_rdata;
  logic        mcu_rdy;
  mapper_e     mapper;
  logic [23:0] rom_mask;
  logic [23:0] saveram_mask;
  logic [22:0] rom_addr;
  logic [15:0] rom_wdata;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic [15:0] rom_rdata;

  logic [15:0] psram [0:8388607];
  logic [7:0]  shadow [logic [23:0]];
  logic [31:0] rng_state;
  int          test_checks;
  int          test_errors;
  int          checks_total;
  int          errors_total;

  snes_cart_top DUT (
    .clk2          (clk2),
    .reset         (reset),
    .snes_addr     (snes_addr),
    .snes_read_n   (snes_read_n),
    .snes_write_n  (snes_write_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_data_in  (snes_data_in),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_rdata     (mcu_rdata),
    .mcu_rdy       (mcu_rdy),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .rom_addr      (rom_addr),
    .rom_wdata     (rom_wdata),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .rom_rdata     (rom_rdata)
  );

  initial begin
    clk2 = 1'b0;
    forever #4 clk2 = ~clk2;
  end

  //////////////////////////////
  // PSRAM model
  //////////////////////////////

  assign rom_rdata = psram[rom_addr];

  always @(posedge clk2) begin
    if (!rom_we_n) begin
      if (!rom_bhe_n) psram[rom_addr][15:8] <= rom_wdata[15:8];
      if (!rom_ble_n) psram[rom_addr][7:0] <= rom_wdata[7:0];
    end
  end

  function automatic logic [15:0] fill_word(input logic [22:0] w);
    logic [31:0] h;
    h = {9'd0, w} * 32'h9e3779b1;
    h = h ^ (h >> 15);
    return h[15:0];
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [7:0] model_byte(input logic [23:0] a);
    logic [15:0] w;
    if (shadow.exists(a)) return shadow[a];
    w = fill_word(a[23:1]);
    // Odd byte lives in the low lane
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  function automatic void map_address(input logic [23:0] a, output logic cart,
                                      output logic wr, output logic [23:0] pa);
    cart = 1'b0;
    wr   = 1'b0;
    pa   = 24'h0;
    if (mapper == MAP_HIROM) begin
      if (a[22:21] == 2'b01 && a[15:13] == 3'b011) begin
        cart = 1'b1;
        wr   = 1'b1;
        pa   = SAVERAM_BASE + ({6'd0, a[20:16], a[12:0]} & saveram_mask);
      end else if (a[22] || a[15]) begin
        cart = 1'b1;
        pa   = {1'b0, a[22:0]} & rom_mask;
      end
    end else begin
      if (a[22:20] == 3'b111 && !a[15]) begin
        cart = 1'b1;
        wr   = 1'b1;
        pa   = SAVERAM_BASE + ({5'd0, a[19:16], a[14:0]} & saveram_mask);
      end else if (a[15]) begin
        cart = 1'b1;
        pa   = {2'd0, a[22:16], a[14:0]} & rom_mask;
      end
    end
  endfunction

  //////////////////////////////
  // Checks and reporting
  //////////////////////////////

  task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    test_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    checks_total += test_checks;
    errors_total += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic console_read(input logic [23:0] a);
    logic        cart;
    logic        wr;
    logic [23:0] pa;
    logic [7:0]  got;
    logic        oe;
    @(posedge clk2);
    snes_addr    <= a;
    snes_cpu_clk <= 1'b0;
    snes_read_n  <= 1'b1;
    repeat (20) @(posedge clk2);
    snes_cpu_clk <= 1'b1;
    snes_read_n  <= 1'b0;
    repeat (19) @(posedge clk2);
    // Sample just before the CPU clock falls
    @(negedge clk2);
    got = snes_data_out;
    oe  = snes_data_oe;
    map_address(a, cart, wr, pa);
    if (cart) compare_byte("snes_data_out", got, model_byte(pa));
    compare_bit("snes_data_oe", oe, cart);
    @(posedge clk2);
    snes_cpu_clk <= 1'b0;
    snes_read_n  <= 1'b1;
  endtask

  task automatic console_write(input logic [23:0] a, input logic [7:0] d);
    logic        cart;
    logic        wr;
    logic [23:0] pa;
    @(posedge clk2);
    snes_addr    <= a;
    snes_cpu_clk <= 1'b0;
    snes_read_n  <= 1'b1;
    snes_write_n <= 1'b1;
    repeat (20) @(posedge clk2);
    snes_cpu_clk <= 1'b1;
    repeat (6) @(posedge clk2);
    snes_write_n <= 1'b0;
    snes_data_in <= d;
    repeat (20) @(posedge clk2);
    snes_write_n <= 1'b1;
    snes_cpu_clk <= 1'b0;
    map_address(a, cart, wr, pa);
    if (wr) shadow[pa] = d;
  endtask

  task automatic wait_mcu_ready(input logic [23:0] a);
    int n;
    n = 0;
    @(negedge clk2);
    while (!mcu_rdy && n < 200) begin
      @(negedge clk2);
      n++;
    end
    assert (mcu_rdy) else begin
      $display("MCU access to %06h never raised mcu_rdy at %0t", a, $time);
      test_errors++;
    end
  endtask

  task automatic mcu_write(input logic [23:0] a, input logic [7:0] d);
    logic [15:0] w;
    @(posedge clk2);
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_wrq   <= 1'b1;
    @(posedge clk2);
    mcu_wrq <= 1'b0;
    wait_mcu_ready(a);
    shadow[a] = d;
    // Written lane takes the byte while the other keeps its old value
    w = psram[a[23:1]];
    compare_byte("psram selected lane", a[0] ? w[7:0] : w[15:8], d);
    compare_byte("psram other lane", a[0] ? w[15:8] : w[7:0], model_byte(a ^ 24'h1));
  endtask

  task automatic mcu_read(input logic [23:0] a);
    @(posedge clk2);
    mcu_addr <= a;
    mcu_rrq  <= 1'b1;
    @(posedge clk2);
    mcu_rrq <= 1'b0;
    wait_mcu_ready(a);
    compare_byte("mcu_rdata", mcu_rdata, model_byte(a));
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    repeat (WDOG_CLKS) @(posedge clk2);
    $display("Watchdog expired after %0d clocks, run did not finish", WDOG_CLKS);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] r;
    logic [23:0] mix_rd [N_MIX];
    logic [23:0] mix_mcu [N_MIX];
    logic [7:0]  mix_dat [N_MIX];

    reset        = 1'b1;
    // Idle bus parked on a ROM address
    snes_addr    = 24'hc00000;
    snes_read_n  = 1'b1;
    snes_write_n = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_data_in = 8'h0;
    mcu_addr     = 24'h0;
    mcu_wdata    = 8'h0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mapper       = MAP_HIROM;
    rom_mask     = 24'hffffff;
    saveram_mask = 24'h001fff;
    rng_state    = 32'hc631;
    test_checks  = 0;
    test_errors  = 0;
    checks_total = 0;
    errors_total = 0;

    for (int i = 0; i < 8388608; i++) begin
      psram[i] = fill_word(i[22:0]);
    end

    repeat (8) @(posedge clk2);
    reset <= 1'b0;

    // Idle state after reset
    repeat (3) @(negedge clk2);
    compare_bit("mcu_rdy", mcu_rdy, 1'b1);
    compare_bit("rom_we_n", rom_we_n, 1'b1);
    compare_bit("snes_data_oe", snes_data_oe, 1'b0);
    finish_test("reset values");

    for (int i = 0; i < N_HI; i++) begin
      @(posedge clk2);
      rom_mask     <= 24'hffffff >> (xorshift32() % 6);
      saveram_mask <= 24'h01ffff >> (xorshift32() % 5);
      r = xorshift32();
      console_read(r[23:0]);
    end
    finish_test("hirom reads");

    @(posedge clk2);
    mapper <= MAP_LOROM;
    for (int i = 0; i < N_LO; i++) begin
      @(posedge clk2);
      rom_mask     <= 24'hffffff >> (xorshift32() % 6);
      saveram_mask <= 24'h01ffff >> (xorshift32() % 5);
      r = xorshift32();
      console_read(r[23:0]);
    end
    finish_test("lorom reads");

    @(posedge clk2);
    mapper       <= MAP_HIROM;
    rom_mask     <= 24'h3fffff;
    saveram_mask <= 24'h00ffff;
    for (int i = 0; i < N_WR; i++) begin
      r = xorshift32();
      console_write({r[23], 2'b01, r[20:16], 3'b011, r[12:0]}, r[31:24]);
      console_read({r[23], 2'b01, r[20:16], 3'b011, r[12:0]});
      r = xorshift32();
      console_write(r[23:0] | 24'h008000, r[31:24]);
      console_read(r[23:0] | 24'h008000);
    end
    finish_test("console writes");

    for (int i = 0; i < N_MCU; i++) begin
      r = xorshift32();
      mcu_write(r[23:0], r[31:24]);
      mcu_read(r[23:0]);
    end
    finish_test("mcu accesses");

    // Console reads stay below 1 MB and MCU traffic above 8 MB
    @(posedge clk2);
    rom_mask <= 24'h0fffff;
    for (int i = 0; i < N_MIX; i++) begin
      r = xorshift32();
      mix_rd[i] = r[23:0] | 24'h400000;
      r = xorshift32();
      mix_mcu[i] = 24'h800000 | (r[23:0] & 24'h3fffff);
      mix_dat[i] = r[31:24];
    end
    fork
      begin
        for (int i = 0; i < N_MIX; i++) console_read(mix_rd[i]);
      end
      begin
        for (int j = 0; j < N_MIX; j++) begin
          mcu_write(mix_mcu[j], mix_dat[j]);
          mcu_read(mix_mcu[j]);
        end
      end
    join
    finish_test("mixed traffic");

    $display("Totals: %0d checks, %0d errors", checks_total, errors_total);
    if (errors_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== snes_cart.f ====
verilog/cart_pkg.sv
verilog/bus_sync.sv
verilog/cart_address_map.sv
verilog/rom_arbiter.sv
verilog/snes_cart_top.sv
dv/tb_snes_cart_assert.sv
dv/tb_snes_cart.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_snes_cart
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): snes_cart.f $(SRCS)
	verilator --binary --timing --assert -j 0 \
		--top-module tb_snes_cart -f snes_cart.f -o Vtb_snes_cart

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "All tests passed!" sim.log || (echo "Simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
